/* hw/z80_pkg.sv */
// shared widths and encodings for the z80 lite core
// F keeps only Z and C live, the other bits stay at their reset value
package z80_pkg;

	localparam int data_w = 8;
	localparam int addr_w = 16;
	localparam int insn_w = 32;

	// z80 r field order: b c d e h l (hl) a
	typedef logic [2:0] reg_idx_t;
	localparam reg_idx_t reg_m = 3'd6; // (hl) slot, no data bus here
	localparam reg_idx_t reg_a = 3'd7;

	localparam int flag_c = 0;
	localparam int flag_z = 6;

	typedef enum logic [3:0] {
		cls_nop,
		cls_ld_rr,
		cls_ld_rn,
		cls_alu_r,
		cls_alu_n,
		cls_incdec,
		cls_jp,
		cls_jp_cc,
		cls_jr,
		cls_out_na,
		cls_halt
	} insn_class_e;

	// add..cp follow the alu field op[5:3], offset by one
	typedef enum logic [3:0] {
		op_pass,
		op_add,
		op_adc,
		op_sub,
		op_sbc,
		op_and,
		op_xor,
		op_or,
		op_cp,
		op_inc,
		op_dec
	} alu_op_e;

endpackage

/* hw/insn_fetch.sv */
`timescale 1ns/1ps
// pc is the address for the next cycle, insn must carry the bytes at
// that address from the following rising edge on (registered memory)
// the first cycle after reset feeds a nop and keeps pc
module insn_fetch #(
	parameter logic [z80_pkg::addr_w-1:0] RESET_PC = '0
) (
	input  logic clk,
	input  logic reset,
	input  logic [z80_pkg::insn_w-1:0] insn,
	input  logic [1:0] len,
	input  logic take_branch,
	input  logic [z80_pkg::addr_w-1:0] branch_target,
	input  logic hold,
	output logic [z80_pkg::addr_w-1:0] pc,
	output logic [23:0] op_bytes
);

	logic [z80_pkg::addr_w-1:0] pc_q; // address of the bytes now on insn
	logic [z80_pkg::addr_w-1:0] next_pc;
	logic [2*z80_pkg::insn_w-1:0] insn_x2;
	logic started;

	assign insn_x2 = {insn, insn};

	// rotate so the opcode lands in byte 0
	always_comb begin
		op_bytes = insn_x2[pc_q[1:0]*8 +: 24];
		if (!started)
			op_bytes = '0;
	end

	always_comb begin
		if (take_branch)
			next_pc = branch_target;
		else if (hold)
			next_pc = pc_q;
		else
			next_pc = pc_q + {{(z80_pkg::addr_w-2){1'b0}}, len};
	end

	assign pc = started ? next_pc : pc_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc_q <= RESET_PC;
			started <= 1'b0;
		end else begin
			pc_q <= pc;
			started <= 1'b1;
		end
	end

endmodule

/* hw/insn_decode.sv */
`timescale 1ns/1ps
// one-cycle decode of the supported subset
// prefixes and anything unrecognised decode as a 1-byte nop
// cc tests use the flags forwarded from the execute stage
module insn_decode (
	input  logic [23:0] op_bytes,
	input  logic [z80_pkg::addr_w-1:0] pc,
	input  logic [z80_pkg::data_w-1:0] flags_fwd,
	output z80_pkg::insn_class_e insn_class,
	output z80_pkg::alu_op_e alu_op,
	output z80_pkg::reg_idx_t dst,
	output z80_pkg::reg_idx_t src,
	output logic [z80_pkg::data_w-1:0] imm,
	output logic [1:0] len,
	output logic take_branch,
	output logic [z80_pkg::addr_w-1:0] branch_target,
	output logic hold
);

	logic [7:0] op;
	logic [7:0] n;
	logic [z80_pkg::addr_w-1:0] nn;
	logic cc_ok;

	assign op = op_bytes[7:0];
	assign n = op_bytes[15:8];
	assign nn = op_bytes[23:8];
	assign imm = n;

	// op[4:3]: nz z nc c
	assign cc_ok = (op[4] ? flags_fwd[z80_pkg::flag_c] : flags_fwd[z80_pkg::flag_z]) == op[3];

	always_comb begin
		insn_class = z80_pkg::cls_nop;
		alu_op = z80_pkg::op_pass;
		dst = op[5:3];
		src = op[2:0];
		len = 2'd1;
		if (op == 8'h76) begin
			insn_class = z80_pkg::cls_halt;
		end else if (op[7:6] == 2'b01 && op[5:3] != z80_pkg::reg_m
				&& op[2:0] != z80_pkg::reg_m) begin
			insn_class = z80_pkg::cls_ld_rr;
		end else if (op[7:6] == 2'b00 && op[2:0] == 3'b110 && op[5:3] != z80_pkg::reg_m) begin
			insn_class = z80_pkg::cls_ld_rn;
			len = 2'd2;
		end else if (op[7:6] == 2'b00 && op[2:1] == 2'b10 && op[5:3] != z80_pkg::reg_m) begin
			insn_class = z80_pkg::cls_incdec;
			alu_op = op[0] ? z80_pkg::op_dec : z80_pkg::op_inc;
		end else if (op[7:6] == 2'b10 && op[2:0] != z80_pkg::reg_m) begin
			insn_class = z80_pkg::cls_alu_r;
			alu_op = z80_pkg::alu_op_e'({1'b0, op[5:3]} + 4'd1);
			dst = z80_pkg::reg_a;
		end else if (op[7:6] == 2'b11 && op[2:0] == 3'b110) begin
			insn_class = z80_pkg::cls_alu_n;
			alu_op = z80_pkg::alu_op_e'({1'b0, op[5:3]} + 4'd1);
			dst = z80_pkg::reg_a;
			len = 2'd2;
		end else if (op == 8'hc3) begin
			insn_class = z80_pkg::cls_jp;
			len = 2'd3;
		end else if (op[7:5] == 3'b110 && op[2:0] == 3'b010) begin
			insn_class = z80_pkg::cls_jp_cc;
			len = 2'd3;
		end else if (op == 8'h18 || (op[7:5] == 3'b001 && op[2:0] == 3'b000)) begin
			insn_class = z80_pkg::cls_jr; // jr e and jr cc,e
			len = 2'd2;
		end else if (op == 8'hd3) begin
			insn_class = z80_pkg::cls_out_na;
			len = 2'd2;
		end
	end

	assign take_branch = insn_class == z80_pkg::cls_jp
		|| (insn_class == z80_pkg::cls_jp_cc && cc_ok)
		|| (insn_class == z80_pkg::cls_jr && (op == 8'h18 || cc_ok));

	// jr counts from the following instruction
	assign branch_target = insn_class == z80_pkg::cls_jr
		? pc + {{(z80_pkg::addr_w-2){1'b0}}, len} + {{(z80_pkg::addr_w-8){n[7]}}, n}
		: nn;

	assign hold = insn_class == z80_pkg::cls_halt;

endmodule

/* hw/alu8.sv */
`timescale 1ns/1ps
// execute stage: operands are captured from the forwarded values at the
// end of decode, results go back to the register file one cycle later
// only Z and C are computed
module alu8 (
	input  logic clk,
	input  logic reset,
	input  z80_pkg::insn_class_e insn_class,
	input  z80_pkg::alu_op_e alu_op,
	input  z80_pkg::reg_idx_t dst,
	input  logic [z80_pkg::data_w-1:0] imm,
	input  logic [z80_pkg::data_w-1:0] a_fwd,
	input  logic [z80_pkg::data_w-1:0] src_fwd,
	input  logic [z80_pkg::data_w-1:0] dst_fwd,
	input  logic [z80_pkg::data_w-1:0] flags_fwd,
	output logic [z80_pkg::data_w-1:0] result,
	output logic [z80_pkg::data_w-1:0] flags_out,
	output logic wr_en,
	output z80_pkg::reg_idx_t wr_idx,
	output logic wr_flags,
	output logic out_strobe,
	output logic [z80_pkg::data_w-1:0] out_a,
	output logic [z80_pkg::data_w-1:0] out_n
);

	localparam int dw = z80_pkg::data_w;

	z80_pkg::insn_class_e ex_class;
	z80_pkg::alu_op_e ex_op;
	z80_pkg::reg_idx_t ex_dst;
	logic [dw-1:0] ex_a;
	logic [dw-1:0] ex_b;
	logic [dw-1:0] ex_f;
	logic [dw-1:0] b_sel;
	logic [dw:0] sum; // top bit is the new carry
	logic cin;

	always_comb begin
		case (insn_class)
			z80_pkg::cls_ld_rr, z80_pkg::cls_alu_r: b_sel = src_fwd;
			z80_pkg::cls_incdec: b_sel = dst_fwd;
			default: b_sel = imm;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			ex_class <= z80_pkg::cls_nop;
		else
			ex_class <= insn_class;
	end

	always_ff @(posedge clk) begin
		ex_op <= alu_op;
		ex_dst <= dst;
		ex_a <= a_fwd;
		ex_b <= b_sel;
		ex_f <= flags_fwd;
	end

	assign cin = ex_f[z80_pkg::flag_c];

	// sub family leaves the borrow in the top bit
	always_comb begin
		case (ex_op)
			z80_pkg::op_add: sum = {1'b0, ex_a} + {1'b0, ex_b};
			z80_pkg::op_adc: sum = {1'b0, ex_a} + {1'b0, ex_b} + {{dw{1'b0}}, cin};
			z80_pkg::op_sub, z80_pkg::op_cp: sum = {1'b0, ex_a} - {1'b0, ex_b};
			z80_pkg::op_sbc: sum = {1'b0, ex_a} - {1'b0, ex_b} - {{dw{1'b0}}, cin};
			z80_pkg::op_and: sum = {1'b0, ex_a & ex_b};
			z80_pkg::op_xor: sum = {1'b0, ex_a ^ ex_b};
			z80_pkg::op_or: sum = {1'b0, ex_a | ex_b};
			z80_pkg::op_inc: sum = {cin, ex_b + 1'b1}; // C unchanged
			z80_pkg::op_dec: sum = {cin, ex_b - 1'b1};
			default: sum = {cin, ex_b};
		endcase
	end

	assign result = sum[dw-1:0];

	always_comb begin
		flags_out = ex_f;
		flags_out[z80_pkg::flag_c] = sum[dw];
		flags_out[z80_pkg::flag_z] = result == '0;
	end

	assign wr_en = ex_class == z80_pkg::cls_ld_rr || ex_class == z80_pkg::cls_ld_rn
		|| ex_class == z80_pkg::cls_incdec
		|| ((ex_class == z80_pkg::cls_alu_r || ex_class == z80_pkg::cls_alu_n)
			&& ex_op != z80_pkg::op_cp);
	assign wr_flags = ex_class == z80_pkg::cls_alu_r || ex_class == z80_pkg::cls_alu_n
		|| ex_class == z80_pkg::cls_incdec;
	assign wr_idx = ex_dst;
	assign out_strobe = ex_class == z80_pkg::cls_out_na;
	assign out_a = ex_a;
	assign out_n = ex_b; // port number rides in the b operand

	assert property (@(posedge clk) disable iff (reset) !(wr_en && out_strobe));

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps
// A F B C D E H L, written at the end of execute
// reads bypass the value being written this cycle
// slot 6 exists only to keep the z80 index map, it is never written
module reg_file (
	input  logic clk,
	input  logic reset,
	input  logic wr_en,
	input  z80_pkg::reg_idx_t wr_idx,
	input  logic [z80_pkg::data_w-1:0] wr_data,
	input  logic wr_flags,
	input  logic [z80_pkg::data_w-1:0] flags_in,
	input  z80_pkg::reg_idx_t src,
	input  z80_pkg::reg_idx_t dst,
	output logic [z80_pkg::data_w-1:0] a_fwd,
	output logic [z80_pkg::data_w-1:0] src_fwd,
	output logic [z80_pkg::data_w-1:0] dst_fwd,
	output logic [z80_pkg::data_w-1:0] flags_fwd
);

	logic [z80_pkg::data_w-1:0] regs [8];
	logic [z80_pkg::data_w-1:0] f;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
			regs[z80_pkg::reg_a] <= '1;
			f <= '1;
		end else begin
			if (wr_en)
				regs[wr_idx] <= wr_data;
			if (wr_flags)
				f <= flags_in;
		end
	end

	always_comb begin
		a_fwd = regs[z80_pkg::reg_a];
		src_fwd = regs[src];
		dst_fwd = regs[dst];
		if (wr_en && wr_idx == z80_pkg::reg_a)
			a_fwd = wr_data;
		if (wr_en && wr_idx == src)
			src_fwd = wr_data;
		if (wr_en && wr_idx == dst)
			dst_fwd = wr_data;
		flags_fwd = wr_flags ? flags_in : f;
	end

	// decode never lets an (hl) form reach write-back
	assert property (@(posedge clk) disable iff (reset) wr_en |-> wr_idx != z80_pkg::reg_m);

endmodule

/* hw/z80_lite_core.sv */
`timescale 1ns/1ps
// two-stage z80 subset core: decode, then execute with write-back
// insn must return the bytes at pc registered on the rising edge
// io_wr is a single-cycle strobe with no back-pressure
module z80_lite_core #(
	parameter logic [z80_pkg::addr_w-1:0] RESET_PC = '0
) (
	input  logic clk,
	input  logic reset,
	input  logic [z80_pkg::insn_w-1:0] insn,
	output logic [z80_pkg::addr_w-1:0] pc,
	output logic io_wr,
	output logic [z80_pkg::addr_w-1:0] io_adr,
	output logic [z80_pkg::data_w-1:0] io_data,
	output logic halted
);

	logic [z80_pkg::addr_w-1:0] cur_pc; // address of the instruction in decode
	logic [23:0] op_bytes;
	z80_pkg::insn_class_e insn_class;
	z80_pkg::alu_op_e alu_op;
	z80_pkg::reg_idx_t dst;
	z80_pkg::reg_idx_t src;
	z80_pkg::reg_idx_t wr_idx;
	logic [z80_pkg::data_w-1:0] imm;
	logic [1:0] len;
	logic take_branch;
	logic hold;
	logic [z80_pkg::addr_w-1:0] branch_target;
	logic [z80_pkg::data_w-1:0] a_fwd;
	logic [z80_pkg::data_w-1:0] src_fwd;
	logic [z80_pkg::data_w-1:0] dst_fwd;
	logic [z80_pkg::data_w-1:0] flags_fwd;
	logic [z80_pkg::data_w-1:0] result;
	logic [z80_pkg::data_w-1:0] flags_out;
	logic [z80_pkg::data_w-1:0] out_a;
	logic [z80_pkg::data_w-1:0] out_n;
	logic wr_en;
	logic wr_flags;
	logic out_strobe;

	insn_fetch #(.RESET_PC(RESET_PC)) u_fetch (
		.clk(clk), .reset(reset), .insn(insn), .len(len),
		.take_branch(take_branch), .branch_target(branch_target), .hold(hold),
		.pc(pc), .op_bytes(op_bytes)
	);

	always_ff @(posedge clk) begin
		if (reset)
			cur_pc <= RESET_PC;
		else
			cur_pc <= pc;
	end

	insn_decode u_decode (
		.op_bytes(op_bytes), .pc(cur_pc), .flags_fwd(flags_fwd),
		.insn_class(insn_class), .alu_op(alu_op), .dst(dst), .src(src), .imm(imm),
		.len(len), .take_branch(take_branch), .branch_target(branch_target), .hold(hold)
	);

	reg_file u_regs (
		.clk(clk), .reset(reset), .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(result),
		.wr_flags(wr_flags), .flags_in(flags_out), .src(src), .dst(dst),
		.a_fwd(a_fwd), .src_fwd(src_fwd), .dst_fwd(dst_fwd), .flags_fwd(flags_fwd)
	);

	alu8 u_alu (
		.clk(clk), .reset(reset), .insn_class(insn_class), .alu_op(alu_op), .dst(dst),
		.imm(imm), .a_fwd(a_fwd), .src_fwd(src_fwd), .dst_fwd(dst_fwd),
		.flags_fwd(flags_fwd), .result(result), .flags_out(flags_out), .wr_en(wr_en),
		.wr_idx(wr_idx), .wr_flags(wr_flags), .out_strobe(out_strobe),
		.out_a(out_a), .out_n(out_n)
	);

	assign io_wr = out_strobe;
	assign io_adr = {out_a, out_n}; // A on the upper address byte
	assign io_data = out_a;

	always_ff @(posedge clk) begin
		if (reset)
			halted <= 1'b0;
		else if (insn_class == z80_pkg::cls_halt)
			halted <= 1'b1;
	end

	// once stopped, the fetch address is frozen and the port stays quiet
	assert property (@(posedge clk) disable iff (reset) halted |=> $stable(pc) && !io_wr);

endmodule

/* verification/core_checker.sv */
`timescale 1ns/1ps
// compares io strobes in order against the queued expectations
// samples on the rising edge, outputs are stable there
module core_checker (
	input logic clk,
	input logic reset,
	input logic io_wr,
	input logic [15:0] io_adr,
	input logic [7:0] io_data,
	input logic halted
);

	logic [15:0] want_adr [$];
	logic [7:0] want_data [$];
	logic was_halted = 1'b0;
	int test_errors = 0;
	int total_errors = 0;
	int tests_run = 0;
	int tests_bad = 0;
	int strobes = 0;

	task automatic expect_pair(input logic [15:0] adr, input logic [7:0] data);
		want_adr.push_back(adr);
		want_data.push_back(data);
	endtask

	task automatic check_strobe();
		logic [15:0] adr;
		logic [7:0] data;
		strobes++;
		if (halted) begin
			$display("port strobe seen while the core is halted");
			test_errors++;
		end
		if (want_adr.size() == 0) begin
			$display("unexpected extra strobe, io_adr 0x%04h io_data 0x%02h", io_adr, io_data);
			test_errors++;
		end else begin
			adr = want_adr.pop_front();
			data = want_data.pop_front();
			if (io_adr !== adr) begin
				$display("FAIL io_adr: expected 0x%04h, got 0x%04h", adr, io_adr);
				test_errors++;
			end
			if (io_data !== data) begin
				$display("FAIL io_data: expected 0x%02h, got 0x%02h", data, io_data);
				test_errors++;
			end
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			was_halted = 1'b0;
		end else begin
			if (was_halted && !halted) begin
				$display("halted went low again without a reset");
				test_errors++;
			end
			was_halted = halted;
			if (io_wr)
				check_strobe();
		end
	end

	task automatic end_test(input string name);
		if (want_adr.size() != 0) begin
			$display("%0d expected strobe(s) never arrived", want_adr.size());
			test_errors += want_adr.size();
		end
		want_adr.delete();
		want_data.delete();
		$display("test %-13s %0d strobes, %0d errors", name, strobes, test_errors);
		tests_run++;
		if (test_errors != 0)
			tests_bad++;
		total_errors += test_errors;
		test_errors = 0;
		strobes = 0;
	endtask

	task automatic report();
		$display("%0d tests run, %0d with errors, %0d errors in total",
			tests_run, tests_bad, total_errors);
	endtask

endmodule

/* verification/tb_top.sv */
`timescale 1ns/1ps
// runs every program of the test table from address 0 until the core halts
// program memory is registered, insn follows pc by one clock
// only pc[7:0] selects a byte, so programs stay under 256 bytes
module tb_top;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic [31:0] insn = '0;
	logic [15:0] pc;
	logic io_wr;
	logic [15:0] io_adr;
	logic [7:0] io_data;
	logic halted;

	logic [7:0] mem [256];
	logic [31:0] rng_state = 32'hdfc6d1a7;
	logic table_ready = 1'b0;

	// test table as flat queues, indexed through per-test start and count
	string test_name [$];
	logic [7:0] prog_bytes [$];
	int prog_start [$];
	int prog_len [$];
	logic [15:0] exp_adr [$];
	logic [7:0] exp_data [$];
	int exp_start [$];
	int exp_cnt [$];

	int pos; // assembly address within the current program
	logic [7:0] m_a;
	logic m_c;
	logic m_z;

	always #4 clk = ~clk;

	z80_lite_core u_z80_lite_core (
		.clk(clk), .reset(reset), .insn(insn), .pc(pc), .io_wr(io_wr),
		.io_adr(io_adr), .io_data(io_data), .halted(halted)
	);

	core_checker u_checker (
		.clk(clk), .reset(reset), .io_wr(io_wr), .io_adr(io_adr),
		.io_data(io_data), .halted(halted)
	);

	// byte at address x goes to lane x mod 4
	function automatic logic [31:0] word_at(input logic [15:0] a);
		logic [31:0] w;
		logic [15:0] x;
		w = '0;
		for (int i = 0; i < 4; i++) begin
			x = a + 16'(i);
			w[{x[1:0], 3'b000} +: 8] = mem[x[7:0]];
		end
		return w;
	endfunction

	always @(posedge clk)
		insn <= word_at(pc);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic next_rand(output logic [7:0] v);
		rng_state = xorshift(rng_state);
		v = rng_state[15:8];
	endtask

	// {carry or borrow, result} from plain integer arithmetic
	function automatic logic [8:0] alu_ref(input logic [2:0] op, input logic [7:0] a,
			input logic [7:0] b, input logic cin);
		int x;
		case (op)
			3'd0: x = int'(a) + int'(b);
			3'd1: x = int'(a) + int'(b) + int'(cin);
			3'd2, 3'd7: x = int'(a) - int'(b);
			3'd3: x = int'(a) - int'(b) - int'(cin);
			3'd4: x = int'(a & b);
			3'd5: x = int'(a ^ b);
			default: x = int'(a | b);
		endcase
		return {x > 255 || x < 0, 8'(x)};
	endfunction

	task automatic begin_test(input string name);
		test_name.push_back(name);
		prog_start.push_back(prog_bytes.size());
		exp_start.push_back(exp_adr.size());
		pos = 0;
		m_a = 8'hff; // F and A come out of reset as ff
		m_c = 1'b1;
		m_z = 1'b1;
	endtask

	task automatic emit(input logic [7:0] b);
		prog_bytes.push_back(b);
		pos++;
	endtask

	task automatic end_prog();
		emit(8'h76);
		prog_len.push_back(pos);
		exp_cnt.push_back(exp_adr.size() - exp_start[exp_start.size() - 1]);
	endtask

	task automatic expect_pair(input logic [15:0] adr, input logic [7:0] data);
		exp_adr.push_back(adr);
		exp_data.push_back(data);
	endtask

	task automatic load_a(input logic [7:0] v);
		emit(8'h3e);
		emit(v);
		m_a = v;
	endtask

	task automatic out_a(input logic [7:0] port);
		emit(8'hd3);
		emit(port);
		expect_pair({m_a, port}, m_a);
	endtask

	task automatic alu_step(input logic [2:0] op, input logic [7:0] b);
		logic [8:0] r;
		r = alu_ref(op, m_a, b, m_c);
		m_c = r[8];
		m_z = r[7:0] == 8'h00;
		if (op != 3'd7)
			m_a = r[7:0]; // cp leaves A alone
	endtask

	task automatic alu_imm(input logic [2:0] op, input logic [7:0] b);
		emit(8'hc6 | {2'b00, op, 3'b000});
		emit(b);
		alu_step(op, b);
	endtask

	task automatic alu_reg(input logic [2:0] op, input logic [2:0] r, input logic [7:0] b);
		emit(8'h06 | {2'b00, r, 3'b000});
		emit(b);
		emit(8'h80 | {2'b00, op, 3'b000} | {5'b00000, r});
		alu_step(op, b);
	endtask

	task automatic step_a(input logic dec);
		emit(dec ? 8'h3d : 8'h3c);
		m_a = dec ? m_a - 8'd1 : m_a + 8'd1;
		m_z = m_a == 8'h00;
	endtask

	// jp cc over a marker out, the port number shows which way it went
	task automatic probe(input logic [1:0] cc);
		logic taken;
		logic [15:0] t_adr;
		logic [15:0] j_adr;
		case (cc)
			2'd0: taken = !m_z; // nz
			2'd1: taken = m_z;
			2'd2: taken = !m_c; // nc
			default: taken = m_c;
		endcase
		t_adr = 16'(pos + 8);
		j_adr = 16'(pos + 10);
		emit(8'hc2 | {3'b000, cc, 3'b000});
		emit(t_adr[7:0]);
		emit(t_adr[15:8]);
		emit(8'hd3);
		emit(8'ha0 | {6'b000000, cc});
		emit(8'hc3);
		emit(j_adr[7:0]);
		emit(j_adr[15:8]);
		emit(8'hd3);
		emit(8'hb0 | {6'b000000, cc});
		expect_pair({m_a, (taken ? 8'hb0 : 8'ha0) | {6'b000000, cc}}, m_a);
	endtask

	task automatic build_loads();
		logic [7:0] v [$];
		logic [7:0] r;
		begin_test("loads");
		for (int i = 0; i < 6; i++) begin
			next_rand(r);
			v.push_back(r);
			emit(8'h06 | {2'b00, 3'(i), 3'b000}); // ld r,n over b..l
			emit(r);
		end
		for (int i = 0; i < 6; i++) begin
			emit(8'h78 | {5'b00000, 3'(i)});
			m_a = v[i];
			out_a(8'h10 + 8'(i));
		end
		next_rand(r);
		load_a(r);
		out_a(8'h17);
		end_prog();
	endtask

	task automatic build_add();
		logic [7:0] x;
		logic [7:0] y;
		begin_test("add_adc");
		load_a(8'hc8);
		alu_imm(3'd0, 8'h64);
		out_a(8'h22);
		probe(2'd3);
		for (int i = 0; i < 3; i++) begin
			next_rand(x);
			next_rand(y);
			load_a(x);
			alu_reg(3'd0, 3'd0, y);
			out_a(8'h20);
			probe(2'd3);
			next_rand(y);
			alu_imm(3'd1, y);
			out_a(8'h21);
			probe(2'd3);
		end
		end_prog();
	endtask

	task automatic build_sub();
		logic [7:0] x;
		logic [7:0] y;
		begin_test("sub_cp");
		for (int i = 0; i < 3; i++) begin
			next_rand(x);
			next_rand(y);
			load_a(x);
			alu_imm(3'd2, y);
			out_a(8'h30);
			probe(2'd2);
			next_rand(x);
			next_rand(y);
			load_a(x);
			alu_reg(3'd3, 3'd1, y); // sbc a,c
			out_a(8'h31);
			probe(2'd2);
			next_rand(x);
			next_rand(y);
			load_a(x);
			alu_imm(3'd7, i == 0 ? x : y);
			probe(2'd1);
			out_a(8'h32);
		end
		end_prog();
	endtask

	task automatic build_logic();
		logic [7:0] r;
		begin_test("logic_incdec");
		next_rand(r);
		load_a(r);
		next_rand(r);
		alu_imm(3'd4, r);
		out_a(8'h40);
		probe(2'd0);
		alu_imm(3'd5, m_a);
		out_a(8'h41);
		probe(2'd0);
		next_rand(r);
		alu_imm(3'd6, r);
		out_a(8'h42);
		probe(2'd0);
		load_a(8'hff);
		step_a(1'b0);
		out_a(8'h43);
		probe(2'd0);
		probe(2'd3);
		alu_imm(3'd2, 8'h01); // sets C for the dec checks
		load_a(8'h01);
		step_a(1'b1);
		probe(2'd1);
		probe(2'd3);
		step_a(1'b1);
		out_a(8'h44);
		emit(8'h06);
		emit(8'hff);
		emit(8'h04); // inc b wraps to 00
		emit(8'h78);
		m_a = 8'h00;
		m_z = 1'b1;
		out_a(8'h45);
		probe(2'd0);
		probe(2'd3);
		end_prog();
	endtask

	task automatic build_flow();
		logic [7:0] code [$];
		begin_test("flow");
		code = '{8'h3e, 8'h11, 8'h18, 8'h02, 8'hd3, 8'he0, 8'hc3, 8'h0d, 8'h00,
			8'hd3, 8'h52, 8'h18, 8'h04, 8'hd3, 8'h51, 8'h18, 8'hf8,
			8'h3e, 8'h05, 8'h3c, 8'h87, 8'hd3, 8'h53, 8'h3d, 8'h47, 8'h80,
			8'hd3, 8'h54};
		foreach (code[i])
			emit(code[i]);
		expect_pair(16'h1151, 8'h11);
		expect_pair(16'h1152, 8'h11);
		expect_pair(16'h0c53, 8'h0c);
		expect_pair(16'h1654, 8'h16);
		end_prog();
	endtask

	task automatic build_halt();
		begin_test("halt");
		load_a(8'h42);
		out_a(8'h60);
		emit(8'h76);
		emit(8'hd3); // never reached
		emit(8'h61);
		emit(8'h3c);
		end_prog();
	endtask

	initial begin
		int limit;
		wait (table_ready);
		limit = 0;
		foreach (prog_len[t])
			limit += prog_len[t] * 4 + 50;
		repeat (limit) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", limit);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		build_loads();
		build_add();
		build_sub();
		build_logic();
		build_flow();
		build_halt();
		table_ready = 1'b1;
		for (int t = 0; t < test_name.size(); t++) begin
			@(posedge clk);
			reset <= 1'b1;
			for (int a = 0; a < 256; a++)
				mem[8'(a)] = a < prog_len[t] ? prog_bytes[prog_start[t] + a] : 8'h00;
			for (int k = 0; k < exp_cnt[t]; k++)
				u_checker.expect_pair(exp_adr[exp_start[t] + k], exp_data[exp_start[t] + k]);
			repeat (8) @(posedge clk);
			reset <= 1'b0;
			@(posedge clk);
			while (!halted)
				@(posedge clk);
			repeat (6) @(posedge clk); // stay halted and quiet
			u_checker.end_test(test_name[t]);
		end
		u_checker.report();
		if (u_checker.total_errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* compile.f */
hw/z80_pkg.sv
hw/insn_fetch.sv
hw/insn_decode.sv
hw/alu8.sv
hw/reg_file.sv
hw/z80_lite_core.sv
verification/core_checker.sv
verification/tb_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_top -f compile.f -o tb_sim
out=$(./obj_dir/tb_sim)
echo "$out"
if echo "$out" | grep -q "SIMULATION PASSED"; then
	exit 0
else
	exit 1
fi
